// File: rob_dispatch.sv
`timescale 1ns/100ps

module rob_dispatch
   import rob_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic       dispatch_valid_a,
   input  logic       dispatch_valid_b,
   input  logic [1:0] retire_count,
   output logic       dispatch_ready,
   output logic       alloc_en_a,
   output logic       alloc_en_b,
   output logic       rob_full,
   output logic       rob_almost_full,
   output logic       rob_empty,
   output rob_idx_t   rob_idx_a,
   output rob_idx_t   rob_idx_b,
   output rob_idx_t   rob_tail,
   output rob_count_t rob_count
);

   // tail and occupancy
   rob_idx_t   tail;
   rob_count_t count;
   rob_count_t count_next;

   // slots taken this cycle, 0 to 2
   logic [1:0] accept_count;

   //////////////////////////////
   // accept
   //////////////////////////////

   // room for a full pair, a lone slot waits the same way
   assign dispatch_ready = (count <= rob_count_t'(rob_depth - 2));

   assign alloc_en_a = dispatch_valid_a & dispatch_ready;
   assign alloc_en_b = dispatch_valid_b & dispatch_ready;

   assign accept_count = {1'b0, alloc_en_a} + {1'b0, alloc_en_b};

   // slot a sits at the tail, b right behind it
   assign rob_idx_a = tail;
   assign rob_idx_b = tail + rob_idx_t'(1);

   //////////////////////////////
   // tail and count
   //////////////////////////////

   // in minus out, both can move on the same edge
   assign count_next = count + rob_count_t'(accept_count) - rob_count_t'(retire_count);

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         tail  <= '0;
         count <= '0;
      end
      else
      begin
         tail  <= tail + rob_idx_t'(accept_count);
         count <= count_next;
      end
   end

   // status straight off the count
   assign rob_full        = (count == rob_count_t'(rob_depth));
   assign rob_almost_full = (count >= rob_count_t'(rob_depth - 2));
   assign rob_empty       = (count == '0);

   assign rob_tail  = tail;
   assign rob_count = count;

   // count stays in range across dispatch and retirement
   a_count_range: assert property (@(posedge clock) disable iff (reset)
      count <= rob_count_t'(rob_depth));

   // slot b never travels alone
   a_pair_order: assert property (@(posedge clock) disable iff (reset)
      dispatch_valid_b |-> dispatch_valid_a);

endmodule

// File: rob_entry_table.sv
`timescale 1ns/100ps

module rob_entry_table
   import rob_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic       alloc_en_a,
   input  logic       alloc_en_b,
   input  rob_idx_t   rob_idx_a,
   input  rob_idx_t   rob_idx_b,
   input  rob_idx_t   rob_head,
   input  opcode_t    opcode_a,
   input  opcode_t    opcode_b,
   input  phys_tag_t  told_a,
   input  phys_tag_t  told_b,
   input  logic       cdb_valid_a,
   input  logic       cdb_valid_b,
   input  logic       cdb_valid_c,
   input  logic       cdb_valid_d,
   input  rob_idx_t   cdb_idx_a,
   input  rob_idx_t   cdb_idx_b,
   input  rob_idx_t   cdb_idx_c,
   input  rob_idx_t   cdb_idx_d,
   input  logic [1:0] retire_count,
   output logic       head_complete,
   output logic       next_complete,
   output logic       head_store,
   output logic       next_store,
   output phys_tag_t  head_told,
   output phys_tag_t  next_told
);

   // per-entry control bits
   logic [rob_depth-1:0] entry_valid;
   logic [rob_depth-1:0] entry_complete;

   // per-entry payload
   logic [rob_depth-1:0] entry_store;
   phys_tag_t            entry_told [rob_depth];

   // entry behind the head
   rob_idx_t next_idx;

   // cdb ports gathered for the loop
   logic [3:0] cdb_valid;
   rob_idx_t   cdb_idx [4];

   assign next_idx = rob_head + rob_idx_t'(1);

   assign cdb_valid  = {cdb_valid_d, cdb_valid_c, cdb_valid_b, cdb_valid_a};
   assign cdb_idx[0] = cdb_idx_a;
   assign cdb_idx[1] = cdb_idx_b;
   assign cdb_idx[2] = cdb_idx_c;
   assign cdb_idx[3] = cdb_idx_d;

   //////////////////////////////
   // valid and complete
   //////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         entry_valid    <= '0;
         entry_complete <= '0;
      end
      else
      begin
         // retired entries free up
         if (retire_count != 2'd0)
         begin
            entry_valid[rob_head]    <= 1'b0;
            entry_complete[rob_head] <= 1'b0;
         end
         if (retire_count == 2'd2)
         begin
            entry_valid[next_idx]    <= 1'b0;
            entry_complete[next_idx] <= 1'b0;
         end
         // new entries start incomplete
         if (alloc_en_a)
         begin
            entry_valid[rob_idx_a]    <= 1'b1;
            entry_complete[rob_idx_a] <= 1'b0;
         end
         if (alloc_en_b)
         begin
            entry_valid[rob_idx_b]    <= 1'b1;
            entry_complete[rob_idx_b] <= 1'b0;
         end
         // all four ports may mark in one cycle
         for (int p = 0; p < 4; p++)
         begin
            if (cdb_valid[p])
               entry_complete[cdb_idx[p]] <= 1'b1;
         end
      end
   end

   //////////////////////////////
   // payload
   //////////////////////////////

   always_ff @(posedge clock)
   begin
      if (alloc_en_a)
      begin
         entry_store[rob_idx_a] <= (opcode_a == opcode_store);
         entry_told[rob_idx_a]  <= told_a;
      end
      if (alloc_en_b)
      begin
         entry_store[rob_idx_b] <= (opcode_b == opcode_store);
         entry_told[rob_idx_b]  <= told_b;
      end
   end

   // head pair view for retirement
   assign head_complete = entry_valid[rob_head] & entry_complete[rob_head];
   assign next_complete = entry_valid[next_idx] & entry_complete[next_idx];
   assign head_store    = entry_store[rob_head];
   assign next_store    = entry_store[next_idx];
   assign head_told     = entry_told[rob_head];
   assign next_told     = entry_told[next_idx];

   // a broadcast must hit a live entry, and only once
   for (genvar g = 0; g < 4; g++)
   begin : g_cdb_check
      a_cdb_target: assert property (@(posedge clock) disable iff (reset)
         cdb_valid[g] |-> entry_valid[cdb_idx[g]] && !entry_complete[cdb_idx[g]]);
   end

endmodule

// File: rob_patterns.mem
// columns: valid_a _ valid_b _ opcode_a _ opcode_b _ told_a _ told_b _ delay, opcode 00 = store
// delay counts cycles from dispatch until the pair may be completed
1_1_03_00_01_02_40
1_1_04_05_03_04_40
1_1_00_06_05_06_40
1_1_07_08_07_08_40
1_1_09_00_09_0a_40
1_1_0a_0b_0b_0c_40
1_1_0c_0d_0d_0e_40
1_1_00_00_0f_10_40
1_1_0e_0f_11_12_40
1_1_10_11_13_14_40
1_1_12_00_15_16_40
1_1_13_14_17_18_40
1_1_15_16_19_1a_40
1_1_00_17_1b_1c_40
1_1_18_19_1d_1e_40
1_1_1a_1b_1f_20_40
1_0_1c_00_21_00_02
1_1_1d_1e_22_23_00
1_0_00_00_24_00_05
1_1_1f_01_25_26_03
1_1_02_00_27_28_01
1_0_03_00_29_00_00

// File: rob_pkg.sv
package rob_pkg;

   //////////////////////////////
   // sizes
   //////////////////////////////

   // entry count, power of two so the pointers wrap by themselves
   localparam int rob_depth = 32;
   localparam int rob_idx_width = 5;

   // occupancy needs one more bit than an index, 0 to rob_depth
   localparam int rob_count_width = rob_idx_width + 1;

   // physical register tag
   localparam int phys_tag_width = 6;

   // decoder opcode
   localparam int opcode_width = 5;

   //////////////////////////////
   // named widths
   //////////////////////////////

   typedef logic [rob_idx_width-1:0]   rob_idx_t;
   typedef logic [rob_count_width-1:0] rob_count_t;
   typedef logic [phys_tag_width-1:0]  phys_tag_t;
   typedef logic [opcode_width-1:0]    opcode_t;

   // stores free no register at retirement
   localparam opcode_t opcode_store = opcode_t'(0);

endpackage

// File: rob_retire.sv
`timescale 1ns/100ps

module rob_retire
   import rob_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic       head_complete,
   input  logic       next_complete,
   input  logic       head_store,
   input  logic       next_store,
   input  phys_tag_t  head_told,
   input  phys_tag_t  next_told,
   input  rob_count_t rob_count,
   output rob_idx_t   rob_head,
   output logic [1:0] retire_count,
   output logic       retire_en_a,
   output logic       retire_en_b,
   output phys_tag_t  retire_told_a,
   output phys_tag_t  retire_told_b
);

   // head pointer
   rob_idx_t head;

   // retirement decisions for the two oldest entries
   logic retire_head;
   logic retire_next;

   //////////////////////////////
   // decide
   //////////////////////////////

   // oldest goes as soon as it is done
   assign retire_head = head_complete;

   // second only alongside the first and only if it really exists
   assign retire_next = head_complete & next_complete & (rob_count >= rob_count_t'(2));

   always_comb
   begin
      retire_count = 2'd0;
      if (retire_next)
         retire_count = 2'd2;
      else if (retire_head)
         retire_count = 2'd1;
   end

   //////////////////////////////
   // free list return
   //////////////////////////////

   // stores hold no old tag to give back
   assign retire_en_a = retire_head & ~head_store;
   assign retire_en_b = retire_next & ~next_store;

   // tags valid only with their enables
   assign retire_told_a = head_told;
   assign retire_told_b = next_told;

   //////////////////////////////
   // head pointer
   //////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
         head <= '0;
      else
         head <= head + rob_idx_t'(retire_count);
   end

   assign rob_head = head;

   // never retire more than is held
   a_retire_le_count: assert property (@(posedge clock) disable iff (reset)
      rob_count_t'(retire_count) <= rob_count);

endmodule

// File: rob_tb.sv
`timescale 1ns/100ps

module rob_tb
   import rob_pkg::*;
();

   localparam int n_lines = 22;
   localparam int cycle_limit = n_lines * 40 + 200;

   logic       clock;
   logic       reset;
   logic       dispatch_valid_a, dispatch_valid_b;
   opcode_t    opcode_a, opcode_b;
   phys_tag_t  told_a, told_b;
   logic       cdb_valid_a, cdb_valid_b, cdb_valid_c, cdb_valid_d;
   rob_idx_t   cdb_idx_a, cdb_idx_b, cdb_idx_c, cdb_idx_d;
   logic       dispatch_ready, retire_en_a, retire_en_b;
   rob_idx_t   rob_idx_a, rob_idx_b, rob_head, rob_tail;
   phys_tag_t  retire_told_a, retire_told_b;
   logic [1:0] retire_count;
   logic       rob_full, rob_almost_full, rob_empty;
   rob_count_t rob_count;

   // pattern words as read from the data file
   logic [47:0] pat [n_lines];

   // reference model in program order with the oldest first
   rob_idx_t  m_idx [$];
   logic      m_store [$];
   phys_tag_t m_told [$];
   logic      m_done [$];
   logic      m_sent [$];
   int        m_ready_at [$];

   integer seed;
   int     n_checks;
   int     errs [6];
   string  names [6] = '{"reset", "indices", "retire_order", "head_block", "fill", "drain"};

   rob_top uut (.*);

   always #4 clock = ~clock;

   //////////////////////////////
   // compare tasks
   //////////////////////////////

   task automatic check_flag(input string name, input logic got, input logic exp, input int t);
      n_checks++;
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         errs[t]++;
      end
   endtask

   task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp,
                            input int t);
      n_checks++;
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         errs[t]++;
      end
   endtask

   task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t exp,
                            input int t);
      n_checks++;
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         errs[t]++;
      end
   endtask

   task automatic check_count(input string name, input rob_count_t got, input rob_count_t exp,
                              input int t);
      n_checks++;
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         errs[t]++;
      end
   endtask

   // model bookkeeping
   task automatic push_entry(input rob_idx_t idx, input opcode_t op, input phys_tag_t tag,
                             input int ready_at);
      m_idx.push_back(idx);
      m_store.push_back(op == opcode_store);
      m_told.push_back(tag);
      m_done.push_back(1'b0);
      m_sent.push_back(1'b0);
      m_ready_at.push_back(ready_at);
   endtask

   task automatic pop_oldest();
      m_idx.delete(0);
      m_store.delete(0);
      m_told.delete(0);
      m_done.delete(0);
      m_sent.delete(0);
      m_ready_at.delete(0);
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial
   begin
      int         cycles;
      int         next_line;
      int         cur_delay;
      int         occ;
      int         exp_ret;
      int         tst;
      int         pick;
      int         total;
      int         cand [$];
      logic       acc;
      logic       finished;
      logic       timed_out;
      logic       saw_full;
      logic       saw_block;
      logic [3:0] cv;
      rob_idx_t   ci [4];
      rob_idx_t   idx_a_seen;
      rob_idx_t   idx_b_seen;
      rob_idx_t   exp_tail;
      rob_idx_t   exp_head;

      seed = 52430;
      clock = 1'b0;
      reset = 1'b1;
      dispatch_valid_a = 1'b0;
      dispatch_valid_b = 1'b0;
      opcode_a = '0;
      opcode_b = '0;
      told_a = '0;
      told_b = '0;
      {cdb_valid_a, cdb_valid_b, cdb_valid_c, cdb_valid_d} = 4'b0;
      {cdb_idx_a, cdb_idx_b, cdb_idx_c, cdb_idx_d} = '0;
      cycles = 0;
      next_line = 0;
      cur_delay = 0;
      finished = 1'b0;
      timed_out = 1'b0;
      saw_full = 1'b0;
      saw_block = 1'b0;
      exp_tail = '0;
      exp_head = '0;
      cv = 4'b0;
      $readmemh("rob_patterns.mem", pat);

      repeat (10) @(posedge clock);
      reset <= 1'b0;

      // idle state straight out of reset
      @(negedge clock);
      check_flag("rob_empty", rob_empty, 1'b1, 0);
      check_flag("dispatch_ready", dispatch_ready, 1'b1, 0);
      check_flag("rob_full", rob_full, 1'b0, 0);
      check_flag("retire_en_a", retire_en_a, 1'b0, 0);
      check_flag("retire_en_b", retire_en_b, 1'b0, 0);
      check_count("retire_count", rob_count_t'(retire_count), '0, 0);
      check_idx("rob_head", rob_head, '0, 0);
      check_idx("rob_tail", rob_tail, '0, 0);
      $display("test %-12s %s  errors %0d", names[0], (errs[0] == 0) ? "ok" : "FAILED", errs[0]);

      while (!finished && !timed_out)
      begin
         @(negedge clock);
         cycles++;
         occ = m_idx.size();

         // status flags against the count rule
         check_count("rob_count", rob_count, rob_count_t'(occ), 4);
         check_flag("rob_full", rob_full, occ == rob_depth, 4);
         check_flag("rob_almost_full", rob_almost_full, occ >= rob_depth - 2, 4);
         check_flag("rob_empty", rob_empty, occ == 0, 4);
         check_flag("dispatch_ready", dispatch_ready, (rob_depth - occ) >= 2, 4);
         if (occ == rob_depth)
            saw_full = 1'b1;

         // pointers wrap modulo depth
         check_idx("rob_tail", rob_tail, exp_tail, 1);
         check_idx("rob_idx_a", rob_idx_a, exp_tail, 1);
         check_idx("rob_idx_b", rob_idx_b, exp_tail + rob_idx_t'(1), 1);
         check_idx("rob_head", rob_head, exp_head, 1);

         // expected retirement from the two oldest
         exp_ret = 0;
         if (occ > 0 && m_done[0])
            exp_ret = 1;
         if (exp_ret == 1 && occ > 1 && m_done[1])
            exp_ret = 2;
         tst = (occ > 0 && !m_done[0]) ? 3 : 2;
         for (int k = 1; k < occ; k++)
            if (tst == 3 && m_done[k])
               saw_block = 1'b1;
         check_count("retire_count", rob_count_t'(retire_count), rob_count_t'(exp_ret), tst);
         check_flag("retire_en_a", retire_en_a, (exp_ret >= 1) ? !m_store[0] : 1'b0, tst);
         check_flag("retire_en_b", retire_en_b, (exp_ret == 2) ? !m_store[1] : 1'b0, tst);
         if (exp_ret >= 1 && !m_store[0])
            check_tag("retire_told_a", retire_told_a, m_told[0], 2);
         if (exp_ret == 2 && !m_store[1])
            check_tag("retire_told_b", retire_told_b, m_told[1], 2);

         // pair taken at the coming edge
         acc = dispatch_valid_a & dispatch_ready;
         idx_a_seen = rob_idx_a;
         idx_b_seen = rob_idx_b;

         if (cycles > cycle_limit)
         begin
            $display("timeout, the run did not drain within %0d cycles", cycle_limit);
            timed_out = 1'b1;
         end
         else if (next_line == n_lines && !dispatch_valid_a && occ == 0)
            finished = 1'b1;
         else
         begin
            @(posedge clock);
            // retire then complete then allocate as the DUT edge does
            repeat (exp_ret) pop_oldest();
            exp_head = exp_head + rob_idx_t'(exp_ret);
            for (int p = 0; p < 4; p++)
               for (int k = 0; k < m_idx.size(); k++)
                  if (cv[p] && m_idx[k] == ci[p])
                     m_done[k] = 1'b1;
            if (acc)
            begin
               push_entry(idx_a_seen, opcode_a, told_a, cycles + cur_delay);
               if (dispatch_valid_b)
                  push_entry(idx_b_seen, opcode_b, told_b, cycles + cur_delay);
               exp_tail = exp_tail + rob_idx_t'(1 + dispatch_valid_b);
            end

            // next pair is held until accepted
            if (acc || !dispatch_valid_a)
            begin
               if (next_line < n_lines)
               begin
                  dispatch_valid_a <= pat[next_line][44];
                  dispatch_valid_b <= pat[next_line][40];
                  opcode_a <= opcode_t'(pat[next_line][39:32]);
                  opcode_b <= opcode_t'(pat[next_line][31:24]);
                  told_a <= phys_tag_t'(pat[next_line][23:16]);
                  told_b <= phys_tag_t'(pat[next_line][15:8]);
                  cur_delay = pat[next_line][7:0];
                  next_line++;
               end
               else
               begin
                  dispatch_valid_a <= 1'b0;
                  dispatch_valid_b <= 1'b0;
               end
            end

            // scrambled completions on up to four ports
            cand.delete();
            for (int k = 0; k < m_idx.size(); k++)
               if (!m_done[k] && !m_sent[k] && cycles >= m_ready_at[k])
                  cand.push_back(k);
            cv = 4'b0;
            for (int p = 0; p < 4; p++)
            begin
               // ports idle at random so younger entries can overtake the head
               if (cand.size() > 0 && ($random(seed) & 1))
               begin
                  pick = $unsigned($random(seed)) % cand.size();
                  ci[p] = m_idx[cand[pick]];
                  m_sent[cand[pick]] = 1'b1;
                  cv[p] = 1'b1;
                  cand.delete(pick);
               end
            end
            {cdb_valid_d, cdb_valid_c, cdb_valid_b, cdb_valid_a} <= cv;
            cdb_idx_a <= ci[0];
            cdb_idx_b <= ci[1];
            cdb_idx_c <= ci[2];
            cdb_idx_d <= ci[3];
         end
      end

      // drained buffer has the head back at the tail
      if (!timed_out)
      begin
         check_flag("rob_empty", rob_empty, 1'b1, 5);
         check_idx("rob_head", rob_head, exp_tail, 5);
         check_idx("rob_tail", rob_tail, exp_tail, 5);
      end
      if (!saw_full)
      begin
         $display("the buffer never reached the full state");
         errs[4]++;
      end
      if (!saw_block)
      begin
         $display("no completed entry was ever seen waiting behind an incomplete head");
         errs[3]++;
      end

      total = 0;
      for (int i = 1; i < 6; i++)
         $display("test %-12s %s  errors %0d", names[i], (errs[i] == 0) ? "ok" : "FAILED",
                  errs[i]);
      for (int i = 0; i < 6; i++)
         total += errs[i];
      $display("checks %0d  errors %0d  cycles %0d", n_checks, total, cycles);
      if (!timed_out && total == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// File: rob_top.sv
`timescale 1ns/100ps

module rob_top
   import rob_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   // dispatch pair
   input  logic       dispatch_valid_a,
   input  logic       dispatch_valid_b,
   input  opcode_t    opcode_a,
   input  opcode_t    opcode_b,
   input  phys_tag_t  told_a,
   input  phys_tag_t  told_b,
   output logic       dispatch_ready,
   output rob_idx_t   rob_idx_a,
   output rob_idx_t   rob_idx_b,
   // completion broadcasts
   input  logic       cdb_valid_a,
   input  logic       cdb_valid_b,
   input  logic       cdb_valid_c,
   input  logic       cdb_valid_d,
   input  rob_idx_t   cdb_idx_a,
   input  rob_idx_t   cdb_idx_b,
   input  rob_idx_t   cdb_idx_c,
   input  rob_idx_t   cdb_idx_d,
   // free list return
   output logic       retire_en_a,
   output logic       retire_en_b,
   output phys_tag_t  retire_told_a,
   output phys_tag_t  retire_told_b,
   output logic [1:0] retire_count,
   // status
   output logic       rob_full,
   output logic       rob_almost_full,
   output logic       rob_empty,
   output rob_idx_t   rob_head,
   output rob_idx_t   rob_tail,
   output rob_count_t rob_count
);

   // dispatch to table
   logic alloc_en_a;
   logic alloc_en_b;

   // table to retire
   logic      head_complete;
   logic      next_complete;
   logic      head_store;
   logic      next_store;
   phys_tag_t head_told;
   phys_tag_t next_told;

   //////////////////////////////
   // parts
   //////////////////////////////

   rob_dispatch u_dispatch (
      .clock            (clock),
      .reset            (reset),
      .dispatch_valid_a (dispatch_valid_a),
      .dispatch_valid_b (dispatch_valid_b),
      .retire_count     (retire_count),
      .dispatch_ready   (dispatch_ready),
      .alloc_en_a       (alloc_en_a),
      .alloc_en_b       (alloc_en_b),
      .rob_full         (rob_full),
      .rob_almost_full  (rob_almost_full),
      .rob_empty        (rob_empty),
      .rob_idx_a        (rob_idx_a),
      .rob_idx_b        (rob_idx_b),
      .rob_tail         (rob_tail),
      .rob_count        (rob_count)
   );

   rob_entry_table u_entry_table (
      .clock         (clock),
      .reset         (reset),
      .alloc_en_a    (alloc_en_a),
      .alloc_en_b    (alloc_en_b),
      .rob_idx_a     (rob_idx_a),
      .rob_idx_b     (rob_idx_b),
      .rob_head      (rob_head),
      .opcode_a      (opcode_a),
      .opcode_b      (opcode_b),
      .told_a        (told_a),
      .told_b        (told_b),
      .cdb_valid_a   (cdb_valid_a),
      .cdb_valid_b   (cdb_valid_b),
      .cdb_valid_c   (cdb_valid_c),
      .cdb_valid_d   (cdb_valid_d),
      .cdb_idx_a     (cdb_idx_a),
      .cdb_idx_b     (cdb_idx_b),
      .cdb_idx_c     (cdb_idx_c),
      .cdb_idx_d     (cdb_idx_d),
      .retire_count  (retire_count),
      .head_complete (head_complete),
      .next_complete (next_complete),
      .head_store    (head_store),
      .next_store    (next_store),
      .head_told     (head_told),
      .next_told     (next_told)
   );

   rob_retire u_retire (
      .clock         (clock),
      .reset         (reset),
      .head_complete (head_complete),
      .next_complete (next_complete),
      .head_store    (head_store),
      .next_store    (next_store),
      .head_told     (head_told),
      .next_told     (next_told),
      .rob_count     (rob_count),
      .rob_head      (rob_head),
      .retire_count  (retire_count),
      .retire_en_a   (retire_en_a),
      .retire_en_b   (retire_en_b),
      .retire_told_a (retire_told_a),
      .retire_told_b (retire_told_b)
   );

endmodule

// File: vlog.f
rob_pkg.sv
rob_dispatch.sv
rob_entry_table.sv
rob_retire.sv
rob_top.sv
rob_tb.sv
